// ==== exc_pkg.sv ====
// **************************************************
// Exception table shared definitions: widths, depth,
// commit delay, empty marker and cause encoding.
// **************************************************
package exc_pkg;

  // Table geometry.
  localparam int ADDR_WIDTH  = 6;   // 64 entries.
  localparam int DATA_WIDTH  = 16;  // Full record.
  localparam int TAG_WIDTH   = 12;  // Tag in low bits.
  localparam int CAUSE_WIDTH = DATA_WIDTH - TAG_WIDTH;  // Cause in top bits.
  localparam int TABLE_DEPTH = 64;  // Entry count.

  // Writes reach the RAM this many edges after capture.
  // The bypass keeps the same number of slots.
  localparam int COMMIT_DELAY = 6;

  // Marks an empty bypass slot or delay stage, never written.
  localparam logic [ADDR_WIDTH-1:0] EMPTY_ADDR = 6'd63;

  // Cause code held in record bits [15:12].
  typedef enum logic [CAUSE_WIDTH-1:0] {
    CAUSE_NONE       = 4'd0,  // No exception recorded.
    CAUSE_MISALIGN   = 4'd1,  // Misaligned access.
    CAUSE_PAGE_FAULT = 4'd2,  // Translation fault.
    CAUSE_ILLEGAL    = 4'd3,  // Illegal opcode.
    CAUSE_BREAKPOINT = 4'd4,  // Debug breakpoint.
    CAUSE_SYSCALL    = 4'd5,  // System call trap.
    CAUSE_OVERFLOW   = 4'd6   // Arithmetic overflow.
  } exc_cause_e;

endpackage

// ==== exc_write_delay.sv ====
// **************************************************
// Exception write delay line: holds each write for
// six edges before committing it to the table RAM.
// **************************************************
`timescale 1ns/100ps

module exc_write_delay import exc_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  except,       // Flush of pending writes.
  input  logic                  wr_en,
  input  logic [ADDR_WIDTH-1:0] wr_addr,
  input  logic [DATA_WIDTH-1:0] wr_data,
  output logic                  commit_en,    // Last stage holds a write.
  output logic [ADDR_WIDTH-1:0] commit_addr,
  output logic [DATA_WIDTH-1:0] commit_data
);

  logic [ADDR_WIDTH-1:0] stage_addr [COMMIT_DELAY];  // EMPTY_ADDR when idle.
  logic [DATA_WIDTH-1:0] stage_data [COMMIT_DELAY];  // Payload, no reset.

  // Address pipe carries the valid state through the empty marker.
  always_ff @(posedge clk) begin
    if (rst || except) begin
      for (int i = 0; i < COMMIT_DELAY; i++) begin
        stage_addr[i] <= EMPTY_ADDR;  // Drop everything in flight.
      end
    end else begin
      stage_addr[0] <= wr_en ? wr_addr : EMPTY_ADDR;  // Bubble when idle.
      for (int i = 1; i < COMMIT_DELAY; i++) begin
        stage_addr[i] <= stage_addr[i-1];
      end
    end
  end

  // Data follows the address; its value in an empty stage is ignored.
  always_ff @(posedge clk) begin
    stage_data[0] <= wr_data;
    for (int i = 1; i < COMMIT_DELAY; i++) begin
      stage_data[i] <= stage_data[i-1];
    end
  end

  // The RAM writes at the edge where the record leaves the last stage.
  assign commit_addr = stage_addr[COMMIT_DELAY-1];
  assign commit_data = stage_data[COMMIT_DELAY-1];
  assign commit_en   = (stage_addr[COMMIT_DELAY-1] != EMPTY_ADDR);

endmodule

// ==== exc_ram.sv ====
// **************************************************
// Exception record RAM: 64 entries, synchronous
// commit write, combinational read at the read address.
// **************************************************
`timescale 1ns/100ps

module exc_ram import exc_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  commit_en,    // Write strobe from delay line.
  input  logic [ADDR_WIDTH-1:0] commit_addr,
  input  logic [DATA_WIDTH-1:0] commit_data,
  input  logic [ADDR_WIDTH-1:0] rd_addr_q,    // Registered read address.
  output logic [DATA_WIDTH-1:0] ram_data
);

  logic [DATA_WIDTH-1:0] mem [TABLE_DEPTH];  // Committed records.

  // Reset leaves every entry at cause none with a zero tag.
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < TABLE_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (commit_en) begin
      mem[commit_addr] <= commit_data;  // Oldest pending write lands.
    end
  end

  // Read port sees a commit from the same edge.
  assign ram_data = mem[rd_addr_q];

endmodule

// ==== exc_bypass.sv ====
// **************************************************
// Exception bypass buffer: six recent writes kept in
// a shift register, newest match forwarded on read.
// **************************************************
`timescale 1ns/100ps

module exc_bypass import exc_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  except,     // Flush empties all slots.
  input  logic                  wr_en,
  input  logic [ADDR_WIDTH-1:0] wr_addr,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic [ADDR_WIDTH-1:0] rd_addr_q,  // Registered read address.
  output logic                  hit,        // Some slot holds rd_addr_q.
  output logic [DATA_WIDTH-1:0] fwd_data    // Newest matching record.
);

  logic [ADDR_WIDTH-1:0]   slot_addr [COMMIT_DELAY];  // Slot 0 is newest.
  logic [DATA_WIDTH-1:0]   slot_data [COMMIT_DELAY];
  logic [COMMIT_DELAY-1:0] match;                     // Per-slot compare.

  // Slot addresses shift every edge, so a write ages out of slot 5
  // on the same edge the delay line commits it.
  always_ff @(posedge clk) begin
    if (rst || except) begin
      for (int i = 0; i < COMMIT_DELAY; i++) begin
        slot_addr[i] <= EMPTY_ADDR;
      end
    end else begin
      slot_addr[0] <= wr_en ? wr_addr : EMPTY_ADDR;  // Empty if no write.
      for (int i = 1; i < COMMIT_DELAY; i++) begin
        slot_addr[i] <= slot_addr[i-1];
      end
    end
  end

  // Record payload moves with its address.
  always_ff @(posedge clk) begin
    slot_data[0] <= wr_data;
    for (int i = 1; i < COMMIT_DELAY; i++) begin
      slot_data[i] <= slot_data[i-1];
    end
  end

  // Empty slots never match, even for a read of the marker address.
  always_comb begin
    for (int i = 0; i < COMMIT_DELAY; i++) begin
      match[i] = (slot_addr[i] == rd_addr_q) && (rd_addr_q != EMPTY_ADDR);
    end
  end

  // Walk oldest to newest so the newest match is the one left standing.
  always_comb begin
    hit      = 1'b0;
    fwd_data = '0;
    for (int i = COMMIT_DELAY - 1; i >= 0; i--) begin
      if (match[i]) begin
        hit      = 1'b1;
        fwd_data = slot_data[i];  // Younger slot overrides.
      end
    end
  end

endmodule

// ==== exc_read_port.sv ====
// **************************************************
// Exception read port: registers the read request
// and decodes the bypass or RAM record.
// **************************************************
`timescale 1ns/100ps

module exc_read_port import exc_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  rd_en,       // Read strobe.
  input  logic [ADDR_WIDTH-1:0] rd_addr,
  output logic [ADDR_WIDTH-1:0] rd_addr_q,   // To RAM and bypass.
  input  logic                  hit,         // Bypass holds a newer record.
  input  logic [DATA_WIDTH-1:0] fwd_data,
  input  logic [DATA_WIDTH-1:0] ram_data,
  output logic                  rd_valid,    // One cycle after rd_en.
  output exc_cause_e            rd_cause,
  output logic [TAG_WIDTH-1:0]  rd_tag,
  output logic                  rd_pending   // Cause other than none.
);

  logic [DATA_WIDTH-1:0] rec;  // Selected record.

  // Address holds between reads so the result tracks later commits.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_addr_q <= '0;
      rd_valid  <= 1'b0;
    end else begin
      rd_valid <= rd_en;  // Fixed one-cycle latency.
      if (rd_en) begin
        rd_addr_q <= rd_addr;
      end
    end
  end

  // Pending writes take priority over committed contents.
  assign rec = hit ? fwd_data : ram_data;

  // Record layout is cause in the top bits, tag below.
  assign rd_cause   = exc_cause_e'(rec[DATA_WIDTH-1:TAG_WIDTH]);
  assign rd_tag     = rec[TAG_WIDTH-1:0];
  assign rd_pending = (rd_cause != CAUSE_NONE);

endmodule

// ==== exc_table_top.sv ====
// **************************************************
// Exception record table top: delayed commit into the
// RAM with a bypass buffer covering the delay window.
// **************************************************
`timescale 1ns/100ps

module exc_table_top import exc_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wr_en,       // Write strobe.
  input  logic [ADDR_WIDTH-1:0] wr_addr,     // 0 to 62 only.
  input  logic [DATA_WIDTH-1:0] wr_data,     // Packed record.
  input  logic                  except,      // Flush pending writes.
  input  logic                  rd_en,       // Read strobe.
  input  logic [ADDR_WIDTH-1:0] rd_addr,
  output logic                  rd_valid,
  output exc_cause_e            rd_cause,
  output logic [TAG_WIDTH-1:0]  rd_tag,
  output logic                  rd_pending
);

  logic                  commit_en;    // Delay line to RAM.
  logic [ADDR_WIDTH-1:0] commit_addr;
  logic [DATA_WIDTH-1:0] commit_data;
  logic [ADDR_WIDTH-1:0] rd_addr_q;    // Read port to RAM and bypass.
  logic [DATA_WIDTH-1:0] ram_data;
  logic                  hit;          // Bypass to read port.
  logic [DATA_WIDTH-1:0] fwd_data;

  // Writes wait here before reaching the RAM.
  exc_write_delay i_exc_write_delay (
    .clk         (clk),
    .rst         (rst),
    .except      (except),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .commit_en   (commit_en),
    .commit_addr (commit_addr),
    .commit_data (commit_data)
  );

  exc_ram i_exc_ram (
    .clk         (clk),
    .rst         (rst),
    .commit_en   (commit_en),
    .commit_addr (commit_addr),
    .commit_data (commit_data),
    .rd_addr_q   (rd_addr_q),
    .ram_data    (ram_data)
  );

  // Same write stream as the delay line, captured on the same edge.
  exc_bypass i_exc_bypass (
    .clk       (clk),
    .rst       (rst),
    .except    (except),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_addr_q (rd_addr_q),
    .hit       (hit),
    .fwd_data  (fwd_data)
  );

  exc_read_port i_exc_read_port (
    .clk        (clk),
    .rst        (rst),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .rd_addr_q  (rd_addr_q),
    .hit        (hit),
    .fwd_data   (fwd_data),
    .ram_data   (ram_data),
    .rd_valid   (rd_valid),
    .rd_cause   (rd_cause),
    .rd_tag     (rd_tag),
    .rd_pending (rd_pending)
  );

endmodule

// ==== exc_table_tb.sv ====
// **************************************************
// Exception table testbench that runs directed and random
// writes, reads and flushes against a reference model.
// **************************************************
`timescale 1ns/100ps

module exc_table_tb import exc_pkg::*; ();

  localparam int RESET_CYCLES    = 5;
  localparam int DIRECTED_CYCLES = 65;    // Sum of the directed sequences below.
  localparam int RANDOM_CYCLES   = 3000;
  localparam int CYCLE_LIMIT     =
    4 * (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES) + 100;

  logic                  clk;
  logic                  rst;
  logic                  wr_en;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [DATA_WIDTH-1:0] wr_data;
  logic                  except;
  logic                  rd_en;
  logic [ADDR_WIDTH-1:0] rd_addr;
  logic                  rd_valid;
  exc_cause_e            rd_cause;
  logic [TAG_WIDTH-1:0]  rd_tag;
  logic                  rd_pending;

  logic [DATA_WIDTH-1:0] shadow [TABLE_DEPTH];  // Committed contents.
  logic [ADDR_WIDTH-1:0] pend_addr [$];         // Writes in flight with the oldest first.
  logic [DATA_WIDTH-1:0] pend_data [$];
  int                    pend_age [$];          // Edges since capture.
  logic                  model_live    = 1'b0;  // Out of reset.
  logic                  exp_due       = 1'b0;  // Read result due now.
  logic [DATA_WIDTH-1:0] exp_rec       = '0;
  int                    cycle_count   = 0;
  int                    reads_checked = 0;

  exc_table_top i_exc_table_top (
    .clk        (clk),
    .rst        (rst),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .except     (except),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .rd_valid   (rd_valid),
    .rd_cause   (rd_cause),
    .rd_tag     (rd_tag),
    .rd_pending (rd_pending)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period.
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic check_cause(input string name, input exc_cause_e exp, input exc_cause_e act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s expected %s (%0h) got %s (%0h)",
                          $time, name, exp.name(), exp, act.name(), act));
    end
  endtask

  task automatic check_tag(input string name, input logic [TAG_WIDTH-1:0] exp,
                           input logic [TAG_WIDTH-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s expected %03h got %03h",
                          $time, name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s expected %b got %b",
                          $time, name, exp, act));
    end
  endtask

  // Newest pending write wins over the committed entry.
  function automatic logic [DATA_WIDTH-1:0] exc_expect(input logic [ADDR_WIDTH-1:0] addr);
    logic [DATA_WIDTH-1:0] rec;
    rec = shadow[addr];
    foreach (pend_addr[i]) begin
      if (pend_addr[i] == addr) begin
        rec = pend_data[i];  // Later entries are younger.
      end
    end
    return rec;
  endfunction

  function automatic logic [DATA_WIDTH-1:0] make_rec(input exc_cause_e cause,
                                                     input logic [TAG_WIDTH-1:0] tag);
    return {cause, tag};  // Cause on top of the tag.
  endfunction

  // Reference model updated on the same edge as the DUT.
  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < TABLE_DEPTH; i++) begin
        shadow[i] = '0;
      end
      pend_addr.delete();
      pend_data.delete();
      pend_age.delete();
      exp_due    = 1'b0;
      model_live = 1'b0;
    end else begin
      // Sixth edge commits even when a flush arrives on it.
      while (pend_age.size() > 0 && pend_age[0] == COMMIT_DELAY - 1) begin
        shadow[pend_addr[0]] = pend_data[0];
        void'(pend_addr.pop_front());
        void'(pend_data.pop_front());
        void'(pend_age.pop_front());
      end
      if (except) begin
        pend_addr.delete();  // Window emptied and the new write dropped.
        pend_data.delete();
        pend_age.delete();
      end else begin
        foreach (pend_age[i]) begin
          pend_age[i] = pend_age[i] + 1;
        end
        if (wr_en) begin
          pend_addr.push_back(wr_addr);
          pend_data.push_back(wr_data);
          pend_age.push_back(0);
        end
      end
      exp_due    = rd_en;                // Result shows until next edge.
      exp_rec    = exc_expect(rd_addr);  // Includes same-cycle write.
      model_live = 1'b1;
    end
  end

  // Outputs are stable mid-cycle.
  always @(negedge clk) begin
    exc_cause_e exp_cause;
    if (model_live) begin
      if (exp_due) begin
        if (rd_valid !== 1'b1) begin
          abort_run("A read strobe got no result: rd_valid was low one cycle later.");
        end
        exp_cause = exc_cause_e'(exp_rec[DATA_WIDTH-1:TAG_WIDTH]);
        check_cause("rd_cause", exp_cause, rd_cause);
        check_tag("rd_tag", exp_rec[TAG_WIDTH-1:0], rd_tag);
        check_flag("rd_pending", exp_cause != CAUSE_NONE, rd_pending);
        reads_checked++;
      end else begin
        check_flag("rd_valid", 1'b0, rd_valid);  // Quiet without a strobe.
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      abort_run("Timeout: the stimulus did not finish within the cycle limit.");
    end
  end

  // One stimulus cycle with inputs changed 2 ns after the edge.
  task automatic drive_cycle(input logic we, input logic [ADDR_WIDTH-1:0] wa,
                             input logic [DATA_WIDTH-1:0] wd, input logic re,
                             input logic [ADDR_WIDTH-1:0] ra, input logic ex);
    wr_en   = we;
    wr_addr = wa;
    wr_data = wd;
    rd_en   = re;
    rd_addr = ra;
    except  = ex;
    @(posedge clk);
    #2;
  endtask

  task automatic write_rec(input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data);
    drive_cycle(1'b1, addr, data, 1'b0, '0, 1'b0);
  endtask

  task automatic read_rec(input logic [ADDR_WIDTH-1:0] addr);
    drive_cycle(1'b0, '0, '0, 1'b1, addr, 1'b0);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) drive_cycle(1'b0, '0, '0, 1'b0, '0, 1'b0);
  endtask

  initial begin
    logic                  we;
    logic                  re;
    logic                  ex;
    logic [ADDR_WIDTH-1:0] wa;
    logic [ADDR_WIDTH-1:0] ra;
    logic [DATA_WIDTH-1:0] wd;
    void'($urandom(32'he85d555c));
    rst      = 1'b1;
    wr_en    = 1'b0;
    wr_addr  = '0;
    wr_data  = '0;
    except   = 1'b0;
    rd_en    = 1'b0;
    rd_addr  = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst = 1'b0;

    // Cleared table including the marker address.
    idle_cycles(3);
    read_rec(6'd0);
    read_rec(6'd17);
    idle_cycles(1);
    read_rec(6'd62);
    read_rec(EMPTY_ADDR);
    idle_cycles(2);

    // Bypass hit next cycle and RAM hit later.
    write_rec(6'd5, make_rec(CAUSE_PAGE_FAULT, 12'h3a1));
    read_rec(6'd5);
    idle_cycles(7);
    read_rec(6'd5);

    // Repeated writes to one entry.
    write_rec(6'd9, make_rec(CAUSE_MISALIGN, 12'h001));
    read_rec(6'd9);
    write_rec(6'd9, make_rec(CAUSE_ILLEGAL, 12'h002));
    read_rec(6'd9);
    write_rec(6'd9, make_rec(CAUSE_SYSCALL, 12'h003));
    write_rec(6'd9, make_rec(CAUSE_OVERFLOW, 12'h004));
    read_rec(6'd9);
    idle_cycles(3);
    read_rec(6'd9);

    // Write and read together.
    drive_cycle(1'b1, 6'd20, make_rec(CAUSE_BREAKPOINT, 12'hbee), 1'b1, 6'd20, 1'b0);
    idle_cycles(1);

    // Flush lands six edges after the write to 33.
    write_rec(6'd30, make_rec(CAUSE_ILLEGAL, 12'h130));
    idle_cycles(7);
    write_rec(6'd33, make_rec(CAUSE_SYSCALL, 12'h133));
    write_rec(6'd34, make_rec(CAUSE_OVERFLOW, 12'h134));
    write_rec(6'd30, make_rec(CAUSE_MISALIGN, 12'h230));
    idle_cycles(3);
    drive_cycle(1'b1, 6'd35, make_rec(CAUSE_PAGE_FAULT, 12'h135), 1'b0, '0, 1'b1);
    read_rec(6'd30);
    read_rec(6'd33);
    read_rec(6'd34);
    read_rec(6'd35);
    idle_cycles(8);
    read_rec(6'd30);
    read_rec(6'd33);

    // Random mix with half the traffic on a few hot entries.
    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      we = ($urandom_range(99) < 45);
      re = ($urandom_range(99) < 50);
      ex = ($urandom_range(99) < 1);  // Rare flush.
      wa = ($urandom_range(1) == 1) ? 6'($urandom_range(7)) : 6'($urandom_range(62));
      ra = ($urandom_range(1) == 1) ? 6'($urandom_range(7)) : 6'($urandom_range(63));
      wd = make_rec(exc_cause_e'(4'($urandom_range(6))), 12'($urandom_range(4095)));
      drive_cycle(we, wa, wd, re, ra, ex);
    end
    idle_cycles(3);

    $display("Checked %0d reads.", reads_checked);
    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== exc_table.f ====
exc_pkg.sv
exc_write_delay.sv
exc_ram.sv
exc_bypass.sv
exc_read_port.sv
exc_table_top.sv
exc_table_tb.sv

// ==== Makefile ====
# Verilator flow for the exception record table.

VERILATOR  ?= verilator
TOP        := exc_table_tb
FILELIST   := exc_table.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0 --Mdir $(BUILD_DIR)
PASS_TEXT  := NO ERRORS
SOURCES    := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only if the pass line shows up in the output.
sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
